//--- rtl/rotator_cfg_pkg.sv
// ######################################
// Weight rotator configuration
// Sizes, reference word layout and the
// output sideband of the weight rotator
// ######################################
package rotator_cfg_pkg;

  localparam int COLS         = 4;
  localparam int WORD_WIDTH   = 8;
  localparam int KW_MAX       = 7;   // odd
  localparam int CI_MAX       = 8;
  localparam int XW_MAX       = 16;
  localparam int XN_MAX       = 4;
  localparam int BANK_DEPTH   = 64;
  localparam int CONFIG_BEATS = 2;
  localparam int BANK_LATENCY = 2;

  localparam int BITS_KW2  = $clog2((KW_MAX + 1) / 2);
  localparam int BITS_CI   = $clog2(CI_MAX);
  localparam int BITS_XW   = $clog2(XW_MAX);
  localparam int BITS_XN   = $clog2(XN_MAX);
  localparam int BITS_ADDR = $clog2(BANK_DEPTH);

  // First beat of a packet, packed in the low data bits
  typedef struct packed {
    logic [BITS_ADDR-1:0] addr_max;  // Last weight address
    logic [BITS_XN-1:0]   xn_1;
    logic [BITS_XW-1:0]   cols_1;
    logic [BITS_CI-1:0]   cin_1;
    logic [BITS_KW2-1:0]  kw2;
  } ref_word_t;

  typedef struct packed {
    logic                is_config;
    logic [BITS_KW2-1:0] kw2;
    logic                is_w_first_clk;
    logic                is_cin_last;
    logic                is_col_1_k2;
    logic                is_w_first_kw2;
    logic                is_w_last;
  } tuser_t;

endpackage

//--- rtl/rotator_ctrl_pkg.sv
// ######################################
// Weight rotator control states
// ######################################
package rotator_ctrl_pkg;

  // Write side, one packet per bank
  typedef enum logic [1:0] {
    W_IDLE, W_GET_REF, W_WRITE, W_SWITCH
  } write_state_e;

  // Read side, config beats then the weight passes
  typedef enum logic [1:0] {
    R_IDLE, R_PASS_CONFIG, R_READ, R_SWITCH
  } read_state_e;

endpackage

//--- rtl/rotator_ctrl.sv
// ######################################
// Weight rotator controller
// Write and read FSMs, bank hand-off
// flags and per-bank enable decode
// ######################################
`timescale 1ns/1ps

module rotator_ctrl (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic                          i_s_tvalid,
  input  logic                          i_s_tlast,
  input  logic                          i_src_ready,
  input  logic                          i_config_done,
  input  logic                          i_pass_done,
  output logic                          o_s_tready,
  output logic                          o_i_write,
  output logic                          o_i_read,
  output logic [1:0]                    o_bank_clr,
  output logic [1:0]                    o_ref_en,
  output logic [1:0]                    o_wr_en,
  output logic [1:0]                    o_rd_en,
  output rotator_ctrl_pkg::read_state_e o_read_state
);
  import rotator_ctrl_pkg::*;

  write_state_e write_state;
  logic [1:0]   done_write;  // Bank holds a full packet
  logic [1:0]   done_read;   // Bank is free for the writer
  logic         s_beat;

  assign o_s_tready = write_state inside {W_GET_REF, W_WRITE};
  assign s_beat     = i_s_tvalid && o_s_tready;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      write_state <= W_IDLE;
    end else begin
      case (write_state)
        W_IDLE:    if (done_read[o_i_write]) write_state <= W_GET_REF;
        W_GET_REF: if (s_beat) write_state <= W_WRITE;
        W_WRITE:   if (s_beat && i_s_tlast) write_state <= W_SWITCH;
        default:   write_state <= W_IDLE;
      endcase
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_read_state <= R_IDLE;
    end else begin
      case (o_read_state)
        R_IDLE:        if (done_write[o_i_read]) o_read_state <= R_PASS_CONFIG;
        R_PASS_CONFIG: if (i_config_done) o_read_state <= R_READ;
        R_READ:        if (i_pass_done) o_read_state <= R_SWITCH;
        default:       o_read_state <= R_IDLE;
      endcase
    end
  end

  // Ping-pong indices
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      o_i_write <= 1'b0;
      o_i_read  <= 1'b0;
    end else begin
      if (write_state == W_SWITCH) o_i_write <= ~o_i_write;
      if (o_read_state == R_SWITCH) o_i_read <= ~o_i_read;
    end
  end

  // Claim a bank for reading as the reader leaves idle, release it at switch
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      done_write <= 2'b00;
      done_read  <= 2'b11;
    end else begin
      if (write_state == W_SWITCH) done_write[o_i_write] <= 1'b1;
      if (o_read_state == R_IDLE && done_write[o_i_read]) done_read[o_i_read] <= 1'b0;
      if (o_read_state == R_SWITCH) begin
        done_read[o_i_read]  <= 1'b1;
        done_write[o_i_read] <= 1'b0;
      end
    end
  end

  always_comb begin
    o_bank_clr = 2'b00;
    o_ref_en   = 2'b00;
    o_wr_en    = 2'b00;
    o_rd_en    = 2'b00;
    if (write_state == W_GET_REF) begin
      o_bank_clr[o_i_write] = 1'b1;    // Rewind both address counters
      o_ref_en[o_i_write]   = s_beat;
    end
    if (write_state == W_WRITE) o_wr_en[o_i_write] = s_beat;
    if (o_read_state inside {R_PASS_CONFIG, R_READ}) o_rd_en[o_i_read] = i_src_ready;
  end

endmodule

//--- rtl/weight_bank.sv
// ######################################
// Weight bank
// Packet RAM with registered reads and a
// read address that loops over weights
// after one pass over the config words
// ######################################
`timescale 1ns/1ps

module weight_bank #(
  parameter int COLS         = rotator_cfg_pkg::COLS,
  parameter int WORD_WIDTH   = rotator_cfg_pkg::WORD_WIDTH,
  parameter int BANK_DEPTH   = rotator_cfg_pkg::BANK_DEPTH,
  parameter int CONFIG_BEATS = rotator_cfg_pkg::CONFIG_BEATS,
  parameter int BANK_LATENCY = rotator_cfg_pkg::BANK_LATENCY
) (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic                       i_clr,
  input  logic                       i_ref_en,
  input  rotator_cfg_pkg::ref_word_t i_ref,
  input  logic                       i_wr_en,
  input  logic [COLS*WORD_WIDTH-1:0] i_wr_data,
  input  logic                       i_rd_en,
  output logic [COLS*WORD_WIDTH-1:0] o_rd_data,
  output rotator_cfg_pkg::ref_word_t o_ref
);
  localparam int WIDTH = COLS * WORD_WIDTH;
  localparam int AW    = $clog2(BANK_DEPTH);

  logic [WIDTH-1:0] mem      [BANK_DEPTH];
  logic [WIDTH-1:0] rd_stage [BANK_LATENCY];
  logic [AW-1:0]    wr_addr, rd_addr, addr_max;

  assign addr_max = AW'(o_ref.addr_max);

  always_ff @(posedge aclk) begin
    if (!aresetn || i_clr) begin
      wr_addr <= '0;
      rd_addr <= '0;
    end else begin
      if (i_wr_en) wr_addr <= wr_addr + 1'b1;
      if (i_rd_en) rd_addr <= (rd_addr == addr_max) ? AW'(CONFIG_BEATS) : rd_addr + 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_wr_en) mem[wr_addr] <= i_wr_data;
    if (i_rd_en) rd_stage[0] <= mem[rd_addr];
    for (int s = 1; s < BANK_LATENCY; s++) begin
      rd_stage[s] <= rd_stage[s-1];   // Output register chain
    end
    if (i_ref_en) o_ref <= i_ref;
  end

  assign o_rd_data = rd_stage[BANK_LATENCY-1];

endmodule

//--- rtl/read_pipe.sv
// ######################################
// Bank read pipe
// Tracks reads in flight and buffers the
// returning words against back-pressure
// ######################################
`timescale 1ns/1ps

module read_pipe #(
  parameter int WIDTH        = rotator_cfg_pkg::COLS * rotator_cfg_pkg::WORD_WIDTH,
  parameter int BANK_LATENCY = rotator_cfg_pkg::BANK_LATENCY
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             i_flush,
  input  logic             i_rd_en,
  input  logic [WIDTH-1:0] i_data,
  input  logic             i_m_tready,
  output logic             o_src_ready,
  output logic             o_m_tvalid,
  output logic [WIDTH-1:0] o_m_tdata
);
  localparam int DEPTH = BANK_LATENCY + 1;
  localparam int PW    = $clog2(DEPTH);
  localparam int CW    = $clog2(DEPTH + 1);

  logic [BANK_LATENCY-1:0] in_flight;   // One bit per read not yet returned
  logic [WIDTH-1:0]        fifo [DEPTH];
  logic [PW-1:0]           wr_ptr, rd_ptr;
  logic [CW-1:0]           count;
  logic [CW:0]             pending;
  logic                    push, pop;

  assign push       = in_flight[BANK_LATENCY-1];
  assign o_m_tvalid = (count != '0);
  assign pop        = o_m_tvalid && i_m_tready;
  assign o_m_tdata  = fifo[rd_ptr];

  // Stored words plus outstanding reads must fit after this cycle's pop
  always_comb begin
    pending = (CW + 1)'(count);
    for (int k = 0; k < BANK_LATENCY; k++) begin
      pending = pending + in_flight[k];
    end
  end
  assign o_src_ready = (pending - pop) < DEPTH;

  always_ff @(posedge aclk) begin
    if (!aresetn || i_flush) begin
      in_flight <= '0;
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
    end else begin
      in_flight <= (in_flight << 1) | BANK_LATENCY'(i_rd_en);
      if (push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CW'(push) - CW'(pop);
    end
  end

  always_ff @(posedge aclk) begin
    if (push) fifo[wr_ptr] <= i_data;
  end

endmodule

//--- rtl/loop_counters.sv
// ######################################
// Rotation loop counters
// Kernel, channel, column and image loops
// giving tlast and the position flags
// ######################################
`timescale 1ns/1ps

module loop_counters #(
  parameter int KW_MAX       = rotator_cfg_pkg::KW_MAX,
  parameter int CI_MAX       = rotator_cfg_pkg::CI_MAX,
  parameter int XW_MAX       = rotator_cfg_pkg::XW_MAX,
  parameter int XN_MAX       = rotator_cfg_pkg::XN_MAX,
  parameter int CONFIG_BEATS = rotator_cfg_pkg::CONFIG_BEATS
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  logic                          i_load,
  input  rotator_ctrl_pkg::read_state_e i_read_state,
  input  logic                          i_beat,
  input  rotator_cfg_pkg::ref_word_t    i_ref,
  output logic                          o_config_done,
  output logic                          o_pass_done,
  output logic                          o_m_tlast,
  output rotator_cfg_pkg::tuser_t       o_m_tuser
);
  import rotator_ctrl_pkg::*;

  localparam int BITS_CFG = $clog2(CONFIG_BEATS + 1);
  localparam int BITS_KW  = $clog2(KW_MAX);
  localparam int BITS_CI  = $clog2(CI_MAX);
  localparam int BITS_XW  = $clog2(XW_MAX);
  localparam int BITS_XN  = $clog2(XN_MAX);

  logic [BITS_CFG-1:0] c_cfg;
  logic [BITS_KW-1:0]  c_kw;
  logic [BITS_CI-1:0]  c_cin;
  logic [BITS_XW-1:0]  c_col, cols_left;
  logic [BITS_XN-1:0]  c_xn;
  logic                l_cfg, l_kw, l_cin, l_col, l_xn;
  logic                en_cfg, en_kw, lc_kw, lc_cin, lc_col;

  assign l_cfg = (c_cfg == BITS_CFG'(CONFIG_BEATS - 1));
  assign l_kw  = (c_kw == BITS_KW'({i_ref.kw2, 1'b0}));   // Kernel width is 2*kw2+1
  assign l_cin = (c_cin == BITS_CI'(i_ref.cin_1));
  assign l_col = (c_col == BITS_XW'(i_ref.cols_1));
  assign l_xn  = (c_xn == BITS_XN'(i_ref.xn_1));

  assign en_cfg = i_beat && (i_read_state == R_PASS_CONFIG);
  assign en_kw  = i_beat && (i_read_state == R_READ);
  assign lc_kw  = en_kw && l_kw;
  assign lc_cin = lc_kw && l_cin;
  assign lc_col = lc_cin && l_col;

  assign o_config_done = en_cfg && l_cfg;
  assign o_pass_done   = lc_col && l_xn;
  assign o_m_tlast     = (i_read_state == R_READ) && l_kw && l_cin && l_col && l_xn;

  // Each loop wraps to zero on its last beat, so a finished pass leaves all at zero
  always_ff @(posedge aclk) begin
    if (!aresetn || i_load) begin
      c_cfg <= '0;
      c_kw  <= '0;
      c_cin <= '0;
      c_col <= '0;
      c_xn  <= '0;
    end else begin
      if (en_cfg) c_cfg <= l_cfg ? '0 : c_cfg + 1'b1;
      if (en_kw) c_kw <= l_kw ? '0 : c_kw + 1'b1;
      if (lc_kw) c_cin <= l_cin ? '0 : c_cin + 1'b1;
      if (lc_cin) c_col <= l_col ? '0 : c_col + 1'b1;
      if (lc_col) c_xn <= l_xn ? '0 : c_xn + 1'b1;
    end
  end

  assign cols_left = BITS_XW'(i_ref.cols_1) - c_col;

  assign o_m_tuser.is_config      = (i_read_state == R_PASS_CONFIG);
  assign o_m_tuser.kw2            = i_ref.kw2;
  assign o_m_tuser.is_w_first_clk = (c_kw == '0) && (c_cin == '0) && (c_col == '0);
  assign o_m_tuser.is_cin_last    = l_kw && l_cin;
  assign o_m_tuser.is_col_1_k2    = (c_col == BITS_XW'(i_ref.kw2));
  assign o_m_tuser.is_w_first_kw2 = cols_left < BITS_XW'(i_ref.kw2);
  assign o_m_tuser.is_w_last      = l_col;

endmodule

//--- rtl/weight_rotator_top.sv
// ######################################
// Weight rotator top
// Ping-pong weight banks fed by an input
// packet, replayed through a skid pipe
// with loop flags on the output stream
// ######################################
`timescale 1ns/1ps

module weight_rotator_top #(
  parameter int COLS         = rotator_cfg_pkg::COLS,
  parameter int WORD_WIDTH   = rotator_cfg_pkg::WORD_WIDTH,
  parameter int KW_MAX       = rotator_cfg_pkg::KW_MAX,
  parameter int CI_MAX       = rotator_cfg_pkg::CI_MAX,
  parameter int XW_MAX       = rotator_cfg_pkg::XW_MAX,
  parameter int XN_MAX       = rotator_cfg_pkg::XN_MAX,
  parameter int BANK_DEPTH   = rotator_cfg_pkg::BANK_DEPTH,
  parameter int CONFIG_BEATS = rotator_cfg_pkg::CONFIG_BEATS,
  parameter int BANK_LATENCY = rotator_cfg_pkg::BANK_LATENCY
) (
  input  logic                           aclk,
  input  logic                           aresetn,
  input  logic                           i_s_tvalid,
  output logic                           o_s_tready,
  input  logic [COLS*WORD_WIDTH-1:0]     i_s_tdata,
  input  logic                           i_s_tlast,
  output logic                           o_m_tvalid,
  input  logic                           i_m_tready,
  output logic [COLS*WORD_WIDTH-1:0]     o_m_tdata,
  output logic                           o_m_tlast,
  output rotator_cfg_pkg::tuser_t        o_m_tuser
);
  import rotator_cfg_pkg::*;
  import rotator_ctrl_pkg::*;

  localparam int DATA_W = COLS * WORD_WIDTH;

  read_state_e       read_state;
  logic              read_idx;
  logic [1:0]        bank_clr, ref_en, wr_en, rd_en;
  logic [DATA_W-1:0] bank_data [2];
  ref_word_t         bank_ref [2];
  ref_word_t         s_ref, rd_ref;
  logic              src_ready, pipe_valid, m_beat;
  logic              config_done, pass_done;

  assign s_ref  = ref_word_t'(i_s_tdata[$bits(ref_word_t)-1:0]);
  assign rd_ref = bank_ref[read_idx];

  // Leftover reads past the pass end stay hidden until the flush
  assign o_m_tvalid = pipe_valid && (read_state inside {R_PASS_CONFIG, R_READ});
  assign m_beat     = o_m_tvalid && i_m_tready;

  rotator_ctrl u_ctrl (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_s_tvalid    (i_s_tvalid),
    .i_s_tlast     (i_s_tlast),
    .i_src_ready   (src_ready),
    .i_config_done (config_done),
    .i_pass_done   (pass_done),
    .o_s_tready    (o_s_tready),
    .o_i_write     (),
    .o_i_read      (read_idx),
    .o_bank_clr    (bank_clr),
    .o_ref_en      (ref_en),
    .o_wr_en       (wr_en),
    .o_rd_en       (rd_en),
    .o_read_state  (read_state)
  );

  for (genvar b = 0; b < 2; b++) begin : g_bank
    weight_bank #(
      .COLS(COLS), .WORD_WIDTH(WORD_WIDTH), .BANK_DEPTH(BANK_DEPTH),
      .CONFIG_BEATS(CONFIG_BEATS), .BANK_LATENCY(BANK_LATENCY)
    ) u_bank (
      .aclk(aclk), .aresetn(aresetn), .i_clr(bank_clr[b]),
      .i_ref_en(ref_en[b]), .i_ref(s_ref),
      .i_wr_en(wr_en[b]), .i_wr_data(i_s_tdata), .i_rd_en(rd_en[b]),
      .o_rd_data(bank_data[b]), .o_ref(bank_ref[b])
    );
  end

  read_pipe #(.WIDTH(DATA_W), .BANK_LATENCY(BANK_LATENCY)) u_pipe (
    .aclk(aclk), .aresetn(aresetn), .i_flush(read_state == R_SWITCH),
    .i_rd_en(|rd_en), .i_data(bank_data[read_idx]), .i_m_tready(i_m_tready),
    .o_src_ready(src_ready), .o_m_tvalid(pipe_valid), .o_m_tdata(o_m_tdata)
  );

  loop_counters #(
    .KW_MAX(KW_MAX), .CI_MAX(CI_MAX), .XW_MAX(XW_MAX),
    .XN_MAX(XN_MAX), .CONFIG_BEATS(CONFIG_BEATS)
  ) u_loops (
    .aclk(aclk), .aresetn(aresetn), .i_load(read_state == R_IDLE),
    .i_read_state(read_state), .i_beat(m_beat), .i_ref(rd_ref),
    .o_config_done(config_done), .o_pass_done(pass_done),
    .o_m_tlast(o_m_tlast), .o_m_tuser(o_m_tuser)
  );

endmodule

//--- test/weight_rotator_checker.sv
// ######################################
// Weight rotator checker
// Bound assertions on the output stream,
// bank hand-off and reset values
// ######################################
`timescale 1ns/1ps

module weight_rotator_checker #(
  parameter int DATA_W = rotator_cfg_pkg::COLS * rotator_cfg_pkg::WORD_WIDTH
) (
  input logic                          aclk,
  input logic                          aresetn,
  input logic                          i_s_tready,
  input logic                          i_m_tvalid,
  input logic                          i_m_tready,
  input logic [DATA_W-1:0]             i_m_tdata,
  input logic                          i_m_tlast,
  input rotator_cfg_pkg::tuser_t       i_m_tuser,
  input rotator_ctrl_pkg::read_state_e i_read_state,
  input logic                          i_read_idx,
  input logic [1:0]                    i_bank_clr,
  input logic [1:0]                    i_ref_en,
  input logic [1:0]                    i_wr_en,
  input logic [1:0]                    i_rd_en
);
  import rotator_ctrl_pkg::*;

  int unsigned failures = 0;   // Read by the testbench

  // Held for a full cycle of reset, so the state registers are cleared
  a_reset_values: assert property (@(posedge aclk)
    (!aresetn && $past(!aresetn)) |->
      (!i_m_tvalid && !i_s_tready && i_wr_en == '0 && i_rd_en == '0 && i_ref_en == '0))
    else begin
      $error("outputs or bank enables active during reset");
      failures++;
    end

  a_hold_stall: assert property (@(posedge aclk) disable iff (!aresetn)
    (i_m_tvalid && !i_m_tready) |=>
      (i_m_tvalid && $stable(i_m_tdata) && $stable(i_m_tuser) && $stable(i_m_tlast)))
    else begin
      $error("output beat changed while stalled");
      failures++;
    end

  // Pass end hands the bank back at once
  a_tlast_switch: assert property (@(posedge aclk) disable iff (!aresetn)
    (i_m_tvalid && i_m_tready && i_m_tlast) |=> (i_read_state == R_SWITCH && !i_m_tvalid))
    else begin
      $error("no bank switch after the last beat of a pass");
      failures++;
    end

  a_bank_guard: assert property (@(posedge aclk) disable iff (!aresetn)
    (i_read_state inside {R_PASS_CONFIG, R_READ}) |->
      (!i_wr_en[i_read_idx] && !i_ref_en[i_read_idx] && !i_bank_clr[i_read_idx]))
    else begin
      $error("write side touched the bank being read");
      failures++;
    end

endmodule

bind weight_rotator_top weight_rotator_checker #(.DATA_W(DATA_W)) u_checker (
  .aclk(aclk), .aresetn(aresetn), .i_s_tready(o_s_tready),
  .i_m_tvalid(o_m_tvalid), .i_m_tready(i_m_tready), .i_m_tdata(o_m_tdata),
  .i_m_tlast(o_m_tlast), .i_m_tuser(o_m_tuser),
  .i_read_state(read_state), .i_read_idx(read_idx),
  .i_bank_clr(bank_clr), .i_ref_en(ref_en), .i_wr_en(wr_en), .i_rd_en(rd_en)
);

//--- test/weight_rotator_tb.sv
// ######################################
// Weight rotator testbench
// Random packets with input gaps and
// output back-pressure, checked beat by
// beat against the loop rules
// ######################################
`timescale 1ns/1ps

module weight_rotator_tb;
  import rotator_cfg_pkg::*;

  localparam int DW     = COLS * WORD_WIDTH;
  localparam int NPKT   = 3;
  localparam int NW_MAX = BANK_DEPTH - CONFIG_BEATS;

  logic          aclk, aresetn;
  logic          i_s_tvalid, o_s_tready, i_s_tlast;
  logic [DW-1:0] i_s_tdata, o_m_tdata;
  logic          o_m_tvalid, i_m_tready, o_m_tlast;
  tuser_t        o_m_tuser;

  ref_word_t     pkt_ref [NPKT];
  logic [DW-1:0] pkt_cfg [NPKT][CONFIG_BEATS];
  logic [DW-1:0] pkt_w   [NPKT][NW_MAX];
  int            pkt_nw  [NPKT];
  int            pkt_len [NPKT];   // Weight beats in one pass
  int            pkts_out  = 0;
  int            wd_cycles = 0;

  weight_rotator_top uut (
    .aclk(aclk), .aresetn(aresetn),
    .i_s_tvalid(i_s_tvalid), .o_s_tready(o_s_tready),
    .i_s_tdata(i_s_tdata), .i_s_tlast(i_s_tlast),
    .o_m_tvalid(o_m_tvalid), .i_m_tready(i_m_tready),
    .o_m_tdata(o_m_tdata), .o_m_tlast(o_m_tlast), .o_m_tuser(o_m_tuser)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic fail_value(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    $display("FAIL t=%0t %s got %0h expected %0h", $time, name, got, exp);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic make_packets();
    int total;
    total = 0;
    for (int p = 0; p < NPKT; p++) begin
      pkt_ref[p].kw2      = BITS_KW2'($urandom_range(0, (KW_MAX - 1) / 2));
      pkt_ref[p].cin_1    = BITS_CI'($urandom_range(0, CI_MAX - 1));
      pkt_ref[p].cols_1   = BITS_XW'($urandom_range(0, XW_MAX - 1));
      pkt_ref[p].xn_1     = BITS_XN'($urandom_range(0, XN_MAX - 1));
      pkt_nw[p]           = $urandom_range(1, NW_MAX);
      pkt_ref[p].addr_max = BITS_ADDR'(CONFIG_BEATS + pkt_nw[p] - 1);
      pkt_len[p] = (2 * int'(pkt_ref[p].kw2) + 1) * (int'(pkt_ref[p].cin_1) + 1)
                 * (int'(pkt_ref[p].cols_1) + 1) * (int'(pkt_ref[p].xn_1) + 1);
      for (int c = 0; c < CONFIG_BEATS; c++) pkt_cfg[p][c] = DW'($urandom);
      for (int w = 0; w < pkt_nw[p]; w++) pkt_w[p][w] = DW'($urandom);
      // Output beats plus input beats of this packet
      total += CONFIG_BEATS + pkt_len[p] + 1 + CONFIG_BEATS + pkt_nw[p];
    end
    wd_cycles = 4 * total + 20;   // Reset and pipeline slack
  endtask

  task automatic send_beat(input logic [DW-1:0] data, input logic last);
    logic taken;
    while ($urandom_range(0, 3) == 0) begin
      i_s_tvalid = 1'b0;
      @(negedge aclk);
    end
    i_s_tvalid = 1'b1;
    i_s_tdata  = data;
    i_s_tlast  = last;
    do begin
      taken = o_s_tready;   // Only moves on the rising edge
      @(negedge aclk);
    end while (!taken);
  endtask

  task automatic send_packet(input int p);
    send_beat(DW'(pkt_ref[p]), 1'b0);
    for (int c = 0; c < CONFIG_BEATS; c++) send_beat(pkt_cfg[p][c], 1'b0);
    for (int w = 0; w < pkt_nw[p]; w++) send_beat(pkt_w[p][w], w == pkt_nw[p] - 1);
    i_s_tvalid = 1'b0;
    i_s_tlast  = 1'b0;
  endtask

  task automatic check_beat(input int p, input int b);
    int     j, kw, ncin, k, ci, col;
    tuser_t exp_user;
    if (b < CONFIG_BEATS) begin
      assert (o_m_tdata == pkt_cfg[p][b])
        else fail_value("o_m_tdata", o_m_tdata, pkt_cfg[p][b]);
      assert (o_m_tuser.is_config) else fail_value("o_m_tuser.is_config", 0, 1);
      assert (!o_m_tlast) else fail_value("o_m_tlast", o_m_tlast, 0);
    end else begin
      j    = b - CONFIG_BEATS;
      kw   = 2 * int'(pkt_ref[p].kw2) + 1;
      ncin = int'(pkt_ref[p].cin_1) + 1;
      k    = j % kw;                                   // Innermost loop
      ci   = (j / kw) % ncin;
      col  = (j / (kw * ncin)) % (int'(pkt_ref[p].cols_1) + 1);
      exp_user                = '0;
      exp_user.kw2            = pkt_ref[p].kw2;
      exp_user.is_w_first_clk = (k == 0) && (ci == 0) && (col == 0);
      exp_user.is_cin_last    = (k == kw - 1) && (ci == ncin - 1);
      exp_user.is_col_1_k2    = (col == int'(pkt_ref[p].kw2));
      exp_user.is_w_first_kw2 = (int'(pkt_ref[p].cols_1) - col) < int'(pkt_ref[p].kw2);
      exp_user.is_w_last      = (col == int'(pkt_ref[p].cols_1));
      assert (o_m_tdata == pkt_w[p][j % pkt_nw[p]])
        else fail_value("o_m_tdata", o_m_tdata, pkt_w[p][j % pkt_nw[p]]);
      assert (o_m_tuser == exp_user) else fail_value("o_m_tuser", o_m_tuser, exp_user);
      assert (o_m_tlast == (j == pkt_len[p] - 1))
        else fail_value("o_m_tlast", o_m_tlast, j == pkt_len[p] - 1);
    end
  endtask

  // Output handshakes checked in the low phase before the rising edge
  initial begin : out_monitor
    int p, b;
    p = 0;
    b = 0;
    forever begin
      @(negedge aclk);
      i_m_tready = ($urandom_range(0, 2) != 0);
      if (aresetn && o_m_tvalid && i_m_tready) begin
        if (p >= NPKT) begin
          abort_run("output beat after the last expected packet");
        end else begin
          check_beat(p, b);
          b++;
          if (b == CONFIG_BEATS + pkt_len[p]) begin
            p++;
            b        = 0;
            pkts_out = p;
          end
        end
      end
    end
  end

  initial begin : checker_watch
    wait (uut.u_checker.failures != 0);
    abort_run("a bound checker assertion failed");
  end

  initial begin : watchdog
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge aclk);
    abort_run($sformatf("timeout, only %0d of %0d packets came out", pkts_out, NPKT));
  end

  initial begin : main_seq
    void'($urandom(32'h8df0));
    aresetn    = 1'b0;
    i_s_tvalid = 1'b0;
    i_s_tdata  = '0;
    i_s_tlast  = 1'b0;
    i_m_tready = 1'b0;
    make_packets();
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    assert (!o_s_tready) else fail_value("o_s_tready", o_s_tready, 0);
    aresetn = 1'b1;
    assert (!o_m_tvalid) else fail_value("o_m_tvalid", o_m_tvalid, 0);
    repeat (2) begin
      if (!o_s_tready) @(negedge aclk);
    end
    assert (o_s_tready) else abort_run("o_s_tready did not rise within 2 cycles of reset");
    for (int p = 0; p < NPKT; p++) send_packet(p);
    wait (pkts_out == NPKT);
    repeat (5) @(negedge aclk);
    if (uut.u_checker.failures == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run("the bound checker reported a failure");
    end
  end

endmodule

//--- weight_rotator_top.f
rtl/rotator_cfg_pkg.sv
rtl/rotator_ctrl_pkg.sv
rtl/rotator_ctrl.sv
rtl/weight_bank.sv
rtl/read_pipe.sv
rtl/loop_counters.sv
rtl/weight_rotator_top.sv
test/weight_rotator_checker.sv
test/weight_rotator_tb.sv

//--- Bender.yml
package:
  name: weight_rotator

sources:
  - files:
      - rtl/rotator_cfg_pkg.sv
      - rtl/rotator_ctrl_pkg.sv
      - rtl/rotator_ctrl.sv
      - rtl/weight_bank.sv
      - rtl/read_pipe.sv
      - rtl/loop_counters.sv
      - rtl/weight_rotator_top.sv
  - target: test
    files:
      - test/weight_rotator_checker.sv
      - test/weight_rotator_tb.sv
